//--- Bender.yml
package:
  name: awe_rowbuffers

sources:
  - include_dirs:
      - .
    files:
      - awe_rowbuf_pkg.sv
      - rowbuf_cmd_if.sv
      - awe_seq_decoder.sv
      - awe_row_bank.sv
      - awe_ce_output.sv
      - awe_rowbuffers.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_awe_rowbuffers.sv

//--- awe_ce_output.sv
`timescale 1ns/1ps

module awe_ce_output
    import awe_rowbuf_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  pixel_pair_t rd_data,
    input  logic        rd_valid,
    output pixel_pair_t pixel_dataout,
    output logic        pixel_dataout_valid,
    output cycle_cnt_t  cycle_counter
);

    `include "awe_rowbuf_defs.svh"

    localparam cycle_cnt_t CNT_WRAP = cycle_cnt_t'(`CYCLE_WRAP);

    //////////////////////////////////////////////////
    // output word
    //////////////////////////////////////////////////

    // bank already registers the pair
    assign pixel_dataout       = rd_data;
    assign pixel_dataout_valid = rd_valid;

    //////////////////////////////////////////////////
    // cycle counter
    //////////////////////////////////////////////////

    // counts the valid outputs of one run modulo 5
    always_ff @(posedge clk) begin
        if (rst || !rd_valid) begin
            cycle_counter <= '0;
        end else if (cycle_counter == CNT_WRAP) begin
            cycle_counter <= '0;
        end else begin
            cycle_counter <= cycle_counter + 1'b1;
        end
    end

    cnt_in_range_a: assert property (
        @(posedge clk) disable iff (rst) cycle_counter <= CNT_WRAP
    );

endmodule

//--- awe_row_bank.sv
`timescale 1ns/1ps

module awe_row_bank
    import awe_rowbuf_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    rowbuf_cmd_if.bank   cmd,
    output pixel_pair_t  rd_data,
    output logic         rd_valid
);

    `include "awe_rowbuf_defs.svh"

    pixel_t ram_even [`BRAM_DEPTH];
    pixel_t ram_odd  [`BRAM_DEPTH];

    pixel_t q_even;
    pixel_t q_odd;

    // rd_en travels beside the data
    logic [`RAM_RD_LATENCY-1:0] rd_pipe;

    // data path below is built for exactly two stages
    if (`RAM_RD_LATENCY != 2) begin : g_latency_check
        $error("awe_row_bank supports a read latency of 2 only");
    end

    //////////////////////////////////////////////////
    // write ports
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (cmd.wr_en_even) begin
            ram_even[cmd.wr_addr] <= cmd.wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd.wr_en_odd) begin
            ram_odd[cmd.wr_addr] <= cmd.wr_data;
        end
    end

    //////////////////////////////////////////////////
    // read ports
    //////////////////////////////////////////////////

    // ram latch holds its value while no read is issued
    always_ff @(posedge clk) begin
        if (cmd.rd_en) begin
            q_even <= ram_even[cmd.rd_addr_even];
            q_odd  <= ram_odd[cmd.rd_addr_odd];
        end
    end

    // output register stage
    always_ff @(posedge clk) begin
        if (rd_pipe[0]) begin
            rd_data.even <= q_even;
            rd_data.odd  <= q_odd;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_pipe <= '0;
        end else begin
            rd_pipe <= {rd_pipe[`RAM_RD_LATENCY-2:0], cmd.rd_en};
        end
    end

    assign rd_valid = rd_pipe[`RAM_RD_LATENCY-1];

    // prime and active never overlap, so the ports stay apart
    no_rd_wr_overlap_a: assert property (
        @(posedge clk) disable iff (rst)
        cmd.rd_en |-> !(cmd.wr_en_even || cmd.wr_en_odd)
    );

endmodule

//--- awe_rowbuf_defs.svh
`ifndef AWE_ROWBUF_DEFS_SVH
`define AWE_ROWBUF_DEFS_SVH

//////////////////////////////////////////////////
// data widths
//////////////////////////////////////////////////

// bits per pixel
`define PIXEL_WIDTH 16

// words in each row buffer ram
`define BRAM_DEPTH 64

// column index, covers half of one ram
`define COL_BITS 5

//////////////////////////////////////////////////
// counters and latencies
//////////////////////////////////////////////////

// cycle counter runs 0 .. CYCLE_WRAP
`define CYCLE_WRAP 4

// execute sample to valid output, per engine
`define CE0_DOUT_LATENCY 3
`define CE1_DOUT_LATENCY 4

// rd_en to rd_data inside a bank
`define RAM_RD_LATENCY 2

`endif

//--- awe_rowbuf_pkg.sv
package awe_rowbuf_pkg;

    `include "awe_rowbuf_defs.svh"

    //////////////////////////////////////////////////
    // pixel and address types
    //////////////////////////////////////////////////

    typedef logic [`PIXEL_WIDTH-1:0] pixel_t;

    // row or column index
    typedef logic [`COL_BITS-1:0] col_t;

    // half-select bit above a column
    typedef logic [`COL_BITS:0] bram_addr_t;

    // odd ram in the upper half of the word
    typedef struct packed {
        pixel_t odd;
        pixel_t even;
    } pixel_pair_t;

    // one pixel sequence word
    typedef struct packed {
        logic half_sel;
        col_t even_col;
        col_t odd_col;
    } pix_seq_t;

    // row rotation, one bit per ram
    typedef logic [1:0] gray_t;

    typedef logic [2:0] cycle_cnt_t;

    // work element states, one-hot
    typedef enum logic [5:0] {
        st_idle          = 6'b000001,
        st_prime_buffer  = 6'b000010,
        st_wait_pfb_load = 6'b000100,
        st_active        = 6'b001000,
        st_wait_job_done = 6'b010000,
        st_send_complete = 6'b100000
    } awe_state_t;

endpackage

//--- awe_rowbuffers.sv
`timescale 1ns/1ps

module awe_rowbuffers
    import awe_rowbuf_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  awe_state_t  state,
    input  gray_t       gray_code,
    input  logic        pfb_rden,
    input  col_t        input_row,
    input  col_t        input_col,
    input  col_t        num_input_cols,
    input  pix_seq_t    pix_seq_datain,
    input  pixel_t      ce0_pixel_datain,
    input  pixel_t      ce1_pixel_datain,
    input  logic        ce0_execute,
    input  logic        ce1_execute,
    output pixel_pair_t ce0_pixel_dataout,
    output pixel_pair_t ce1_pixel_dataout,
    output logic        ce0_pixel_dataout_valid,
    output logic        ce1_pixel_dataout_valid,
    output cycle_cnt_t  ce0_cycle_counter,
    output cycle_cnt_t  ce1_cycle_counter
);

    `include "awe_rowbuf_defs.svh"

    pixel_pair_t ce0_rd_data;
    pixel_pair_t ce1_rd_data;
    logic        ce0_rd_valid;
    logic        ce1_rd_valid;

    rowbuf_cmd_if ce0_cmd_if ();
    rowbuf_cmd_if ce1_cmd_if ();

    //////////////////////////////////////////////////
    // command decode
    //////////////////////////////////////////////////

    awe_seq_decoder seq_decoder_i (
        .clk              (clk),
        .rst              (rst),
        .state            (state),
        .gray_code        (gray_code),
        .pfb_rden         (pfb_rden),
        .input_row        (input_row),
        .input_col        (input_col),
        .num_input_cols   (num_input_cols),
        .pix_seq_datain   (pix_seq_datain),
        .ce0_pixel_datain (ce0_pixel_datain),
        .ce1_pixel_datain (ce1_pixel_datain),
        .ce0_execute      (ce0_execute),
        .ce1_execute      (ce1_execute),
        .ce0_cmd          (ce0_cmd_if.decoder),
        .ce1_cmd          (ce1_cmd_if.decoder)
    );

    //////////////////////////////////////////////////
    // per engine banks and outputs
    //////////////////////////////////////////////////

    awe_row_bank ce0_bank_i (
        .clk      (clk),
        .rst      (rst),
        .cmd      (ce0_cmd_if.bank),
        .rd_data  (ce0_rd_data),
        .rd_valid (ce0_rd_valid)
    );

    awe_row_bank ce1_bank_i (
        .clk      (clk),
        .rst      (rst),
        .cmd      (ce1_cmd_if.bank),
        .rd_data  (ce1_rd_data),
        .rd_valid (ce1_rd_valid)
    );

    awe_ce_output ce0_output_i (
        .clk                 (clk),
        .rst                 (rst),
        .rd_data             (ce0_rd_data),
        .rd_valid            (ce0_rd_valid),
        .pixel_dataout       (ce0_pixel_dataout),
        .pixel_dataout_valid (ce0_pixel_dataout_valid),
        .cycle_counter       (ce0_cycle_counter)
    );

    awe_ce_output ce1_output_i (
        .clk                 (clk),
        .rst                 (rst),
        .rd_data             (ce1_rd_data),
        .rd_valid            (ce1_rd_valid),
        .pixel_dataout       (ce1_pixel_dataout),
        .pixel_dataout_valid (ce1_pixel_dataout_valid),
        .cycle_counter       (ce1_cycle_counter)
    );

    // end to end read latency through decoder and bank
    ce0_latency_a: assert property (
        @(posedge clk) disable iff (rst)
        (ce0_execute && state == st_active) |-> ##`CE0_DOUT_LATENCY ce0_pixel_dataout_valid
    );

    ce1_latency_a: assert property (
        @(posedge clk) disable iff (rst)
        (ce1_execute && state == st_active) |-> ##`CE1_DOUT_LATENCY ce1_pixel_dataout_valid
    );

endmodule

//--- awe_rowbuffers_trace.txt
# state gray pfb row col last seq px0 px1 ex0 ex1 exp0 exp1, all hex
# exp0 and exp1 are the {odd,even} pairs for this line's execute strobes, - for none
01 0 0 00 00 00 000 0000 0000 0 0 - -
02 0 1 00 00 03 000 1000 2000 0 0 - -
02 0 1 00 01 03 000 1001 2001 0 0 - -
02 0 1 00 02 03 000 1002 2002 0 0 - -
02 0 1 00 03 03 000 1003 2003 0 0 - -
02 0 1 00 04 04 000 1004 2004 0 0 - -
02 0 1 01 00 03 000 1100 2100 0 0 - -
02 0 1 01 01 03 000 1101 2101 0 0 - -
02 0 1 01 02 03 000 1102 2102 0 0 - -
02 0 1 01 03 03 000 1103 2103 0 0 - -
02 0 1 02 00 03 000 1200 2200 0 0 - -
02 0 1 02 01 03 000 1201 2201 0 0 - -
02 0 1 02 02 03 000 1202 2202 0 0 - -
02 0 1 02 03 03 000 1203 2203 0 0 - -
02 0 1 00 04 03 000 1eee 2eee 0 0 - -
04 0 0 00 00 00 000 0000 0000 0 0 - -
08 0 0 00 00 00 000 0000 0000 1 1 10001000 20012001
08 0 0 00 00 00 021 0000 0000 1 1 10011001 21012200
08 0 0 00 00 00 401 0000 0000 1 1 11011200 21032202
08 0 0 00 00 00 443 0000 0000 1 1 11031202 21012201
08 3 0 00 00 00 021 0000 0000 1 1 11011201 21002003
08 1 0 00 00 00 060 0000 0000 1 1 11001003 21002001
08 2 0 00 00 00 420 0000 0000 1 1 11001001 21012202
08 3 0 00 00 00 041 0000 0000 1 0 11011202 -
08 0 0 00 00 00 000 0000 0000 0 0 - -
08 0 0 00 00 00 084 0000 0000 1 1 10041004 21022203
08 0 0 00 00 00 462 0000 0000 1 0 11021203 -
08 0 0 00 00 00 000 0000 0000 0 1 - 20042004
10 0 0 00 00 00 084 0000 0000 0 0 - -
20 0 0 00 00 00 000 0000 0000 0 0 - -

//--- awe_seq_decoder.sv
`timescale 1ns/1ps

module awe_seq_decoder
    import awe_rowbuf_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  awe_state_t    state,
    input  gray_t         gray_code,
    input  logic          pfb_rden,
    input  col_t          input_row,
    input  col_t          input_col,
    input  col_t          num_input_cols,
    input  pix_seq_t      pix_seq_datain,
    input  pixel_t        ce0_pixel_datain,
    input  pixel_t        ce1_pixel_datain,
    input  logic          ce0_execute,
    input  logic          ce1_execute,
    rowbuf_cmd_if.decoder ce0_cmd,
    rowbuf_cmd_if.decoder ce1_cmd
);

    logic       prime_wr;
    logic       wr_even;
    logic       wr_odd;
    bram_addr_t wr_addr;
    logic       ce0_rd;
    logic       ce1_rd_q;
    pix_seq_t   ce1_seq_q;
    gray_t      ce1_gray_q;

    // gray bit 1 steers the even ram, bit 0 the odd ram
    function automatic bram_addr_t even_addr(pix_seq_t seq, gray_t gray);
        return {gray[1] ^ seq.half_sel, seq.even_col};
    endfunction

    function automatic bram_addr_t odd_addr(pix_seq_t seq, gray_t gray);
        return {gray[0] ^ seq.half_sel, seq.odd_col};
    endfunction

    //////////////////////////////////////////////////
    // priming writes, same rule for both engines
    //////////////////////////////////////////////////

    assign prime_wr = (state == st_prime_buffer) && pfb_rden
                      && (input_col <= num_input_cols);

    always_comb begin
        wr_even = 1'b0;
        wr_odd  = 1'b0;
        wr_addr = {1'b0, input_col};
        if (prime_wr) begin
            case (input_row)
                // row 0 lands in the lower half of both rams
                col_t'(0): begin
                    wr_even = 1'b1;
                    wr_odd  = 1'b1;
                end
                col_t'(1): begin
                    wr_odd  = 1'b1;
                    wr_addr = {1'b1, input_col};
                end
                col_t'(2): begin
                    wr_even = 1'b1;
                    wr_addr = {1'b1, input_col};
                end
                default: begin
                end
            endcase
        end
    end

    assign ce0_rd = (state == st_active) && ce0_execute;

    //////////////////////////////////////////////////
    // engine 0 commands
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            ce0_cmd.wr_en_even <= 1'b0;
            ce0_cmd.wr_en_odd  <= 1'b0;
            ce0_cmd.rd_en      <= 1'b0;
        end else begin
            ce0_cmd.wr_en_even <= wr_even;
            ce0_cmd.wr_en_odd  <= wr_odd;
            ce0_cmd.rd_en      <= ce0_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_even || wr_odd) begin
            ce0_cmd.wr_addr <= wr_addr;
            ce0_cmd.wr_data <= ce0_pixel_datain;
        end
        if (ce0_rd) begin
            ce0_cmd.rd_addr_even <= even_addr(pix_seq_datain, gray_code);
            ce0_cmd.rd_addr_odd  <= odd_addr(pix_seq_datain, gray_code);
        end
    end

    //////////////////////////////////////////////////
    // engine 1 commands
    //////////////////////////////////////////////////

    // read strobe one cycle behind, sequence word taken one edge later
    always_ff @(posedge clk) begin
        if (rst) begin
            ce1_rd_q           <= 1'b0;
            ce1_cmd.wr_en_even <= 1'b0;
            ce1_cmd.wr_en_odd  <= 1'b0;
            ce1_cmd.rd_en      <= 1'b0;
        end else begin
            ce1_rd_q           <= (state == st_active) && ce1_execute;
            ce1_cmd.wr_en_even <= wr_even;
            ce1_cmd.wr_en_odd  <= wr_odd;
            ce1_cmd.rd_en      <= ce1_rd_q;
        end
    end

    always_ff @(posedge clk) begin
        ce1_seq_q  <= pix_seq_datain;
        ce1_gray_q <= gray_code;
        if (wr_even || wr_odd) begin
            ce1_cmd.wr_addr <= wr_addr;
            ce1_cmd.wr_data <= ce1_pixel_datain;
        end
    end

    assign ce1_cmd.rd_addr_even = even_addr(ce1_seq_q, ce1_gray_q);
    assign ce1_cmd.rd_addr_odd  = odd_addr(ce1_seq_q, ce1_gray_q);

    // the work element FSM must never hold two states at once
    state_onehot_a: assert property (
        @(posedge clk) disable iff (rst) $onehot(state)
    );

endmodule

//--- rowbuf_cmd_if.sv
`timescale 1ns/1ps

// write and read commands for one engine's bank
interface rowbuf_cmd_if
    import awe_rowbuf_pkg::*;
();

    logic       wr_en_even;
    logic       wr_en_odd;
    bram_addr_t wr_addr;
    pixel_t     wr_data;

    logic       rd_en;
    bram_addr_t rd_addr_even;
    bram_addr_t rd_addr_odd;

    modport decoder (
        output wr_en_even, wr_en_odd, wr_addr, wr_data,
        output rd_en, rd_addr_even, rd_addr_odd
    );

    modport bank (
        input wr_en_even, wr_en_odd, wr_addr, wr_data,
        input rd_en, rd_addr_even, rd_addr_odd
    );

endinterface

//--- tb_awe_rowbuffers.sv
`timescale 1ns/1ps

module tb_awe_rowbuffers
    import awe_rowbuf_pkg::*;
();

    `include "awe_rowbuf_defs.svh"

    localparam int    DRIVE_DELAY   = 2;
    localparam int    DRAIN_TIMEOUT = 20;
    localparam string TRACE_FILE    = "awe_rowbuffers_trace.txt";

    logic        clk;
    logic        rst;
    awe_state_t  state;
    gray_t       gray_code;
    logic        pfb_rden;
    col_t        input_row;
    col_t        input_col;
    col_t        num_input_cols;
    pix_seq_t    pix_seq_datain;
    pixel_t      ce0_pixel_datain;
    pixel_t      ce1_pixel_datain;
    logic        ce0_execute;
    logic        ce1_execute;
    pixel_pair_t ce0_pixel_dataout;
    pixel_pair_t ce1_pixel_dataout;
    logic        ce0_pixel_dataout_valid;
    logic        ce1_pixel_dataout_valid;
    cycle_cnt_t  ce0_cycle_counter;
    cycle_cnt_t  ce1_cycle_counter;

    int unsigned edge_cnt = 0;
    int unsigned value_errors = 0;
    int unsigned other_errors = 0;

    // expected pairs and the edge where each one is due
    pixel_pair_t exp0_q[$];
    pixel_pair_t exp1_q[$];
    int unsigned due0_q[$];
    int unsigned due1_q[$];

    // length of the current run of valid outputs
    int unsigned run_len [2];
    logic        prev_valid [2];

    awe_rowbuffers awe_rowbuffers_i (
        .clk                     (clk),
        .rst                     (rst),
        .state                   (state),
        .gray_code               (gray_code),
        .pfb_rden                (pfb_rden),
        .input_row               (input_row),
        .input_col               (input_col),
        .num_input_cols          (num_input_cols),
        .pix_seq_datain          (pix_seq_datain),
        .ce0_pixel_datain        (ce0_pixel_datain),
        .ce1_pixel_datain        (ce1_pixel_datain),
        .ce0_execute             (ce0_execute),
        .ce1_execute             (ce1_execute),
        .ce0_pixel_dataout       (ce0_pixel_dataout),
        .ce1_pixel_dataout       (ce1_pixel_dataout),
        .ce0_pixel_dataout_valid (ce0_pixel_dataout_valid),
        .ce1_pixel_dataout_valid (ce1_pixel_dataout_valid),
        .ce0_cycle_counter       (ce0_cycle_counter),
        .ce1_cycle_counter       (ce1_cycle_counter)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("** Error (%0t): %s is %h, expected %h", $time, what, got, expected);
            value_errors++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("Failure at %0t: %s", $time, msg);
        other_errors++;
    endtask

    // outputs seen at the falling edge are what the next rising edge samples
    task automatic watch_engine(input int eng, input logic valid, input pixel_pair_t data,
                                input cycle_cnt_t cnt);
        int unsigned now_edge;
        int unsigned due;
        int          pending;
        pixel_pair_t exp_pair;
        now_edge = edge_cnt + 1;
        pending  = (eng == 0) ? due0_q.size() : due1_q.size();
        if (valid) begin
            if (pending == 0) begin
                report_failure($sformatf("engine %0d raised valid with no read pending", eng));
            end else begin
                if (eng == 0) begin
                    exp_pair = exp0_q.pop_front();
                    due      = due0_q.pop_front();
                end else begin
                    exp_pair = exp1_q.pop_front();
                    due      = due1_q.pop_front();
                end
                check_value($sformatf("engine %0d pixel pair", eng), data, exp_pair);
                check_value($sformatf("engine %0d valid edge", eng), now_edge, due);
            end
            check_value($sformatf("engine %0d cycle counter", eng), cnt,
                        run_len[eng] % (`CYCLE_WRAP + 1));
            run_len[eng]++;
        end else begin
            if (pending != 0) begin
                due = (eng == 0) ? due0_q[0] : due1_q[0];
                // read is late, drop it so later reads stay aligned
                if (due <= now_edge) begin
                    report_failure($sformatf("engine %0d gave no valid output at edge %0d",
                                             eng, due));
                    if (eng == 0) begin
                        void'(exp0_q.pop_front());
                        void'(due0_q.pop_front());
                    end else begin
                        void'(exp1_q.pop_front());
                        void'(due1_q.pop_front());
                    end
                end
            end
            if (!prev_valid[eng]) begin
                check_value($sformatf("engine %0d idle cycle counter", eng), cnt, 0);
            end
            run_len[eng] = 0;
        end
        prev_valid[eng] = valid;
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            watch_engine(0, ce0_pixel_dataout_valid, ce0_pixel_dataout, ce0_cycle_counter);
            watch_engine(1, ce1_pixel_dataout_valid, ce1_pixel_dataout, ce1_cycle_counter);
        end
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    task automatic drive_idle();
        state            = st_idle;
        gray_code        = '0;
        pfb_rden         = 1'b0;
        input_row        = '0;
        input_col        = '0;
        num_input_cols   = '0;
        pix_seq_datain   = '0;
        ce0_pixel_datain = '0;
        ce1_pixel_datain = '0;
        ce0_execute      = 1'b0;
        ce1_execute      = 1'b0;
    endtask

    // execute is sampled at the next edge
    task automatic queue_expect(input int eng, input string s, input int line_no);
        logic [31:0] val;
        int unsigned due;
        due = edge_cnt + 1 + ((eng == 0) ? `CE0_DOUT_LATENCY : `CE1_DOUT_LATENCY);
        if (s == "-" || $sscanf(s, "%h", val) != 1) begin
            report_failure($sformatf("trace line %0d starts a read on engine %0d without an expected pair",
                                     line_no, eng));
        end else if (eng == 0) begin
            exp0_q.push_back(pixel_pair_t'(val));
            due0_q.push_back(due);
        end else begin
            exp1_q.push_back(pixel_pair_t'(val));
            due1_q.push_back(due);
        end
    endtask

    task automatic replay_trace(input int fd);
        string       line;
        string       exp0_s;
        string       exp1_s;
        logic [31:0] f [11];
        int          n_fields;
        int          line_no;
        int          stim_lines;
        line_no    = 0;
        stim_lines = 0;
        while ($fgets(line, fd) != 0) begin
            line_no++;
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n_fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %s %s",
                               f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                               f[10], exp0_s, exp1_s);
            if (n_fields != 13) begin
                report_failure($sformatf("trace line %0d has %0d fields instead of 13",
                                         line_no, n_fields));
                continue;
            end
            @(posedge clk);
            #DRIVE_DELAY;
            state            = awe_state_t'(f[0][5:0]);
            gray_code        = f[1][1:0];
            pfb_rden         = f[2][0];
            input_row        = f[3][`COL_BITS-1:0];
            input_col        = f[4][`COL_BITS-1:0];
            num_input_cols   = f[5][`COL_BITS-1:0];
            pix_seq_datain   = pix_seq_t'(f[6][10:0]);
            ce0_pixel_datain = f[7][`PIXEL_WIDTH-1:0];
            ce1_pixel_datain = f[8][`PIXEL_WIDTH-1:0];
            ce0_execute      = f[9][0];
            ce1_execute      = f[10][0];
            stim_lines++;
            if (ce0_execute) begin
                queue_expect(0, exp0_s, line_no);
            end
            if (ce1_execute) begin
                queue_expect(1, exp1_s, line_no);
            end
        end
        if (stim_lines == 0) begin
            report_failure("trace file holds no stimulus lines");
        end
    endtask

    task automatic drain_reads();
        int wait_cnt;
        @(posedge clk);
        #DRIVE_DELAY;
        drive_idle();
        wait_cnt = 0;
        while ((exp0_q.size() + exp1_q.size()) != 0 && wait_cnt < DRAIN_TIMEOUT) begin
            @(posedge clk);
            wait_cnt++;
        end
        if ((exp0_q.size() + exp1_q.size()) != 0) begin
            report_failure($sformatf("trace exhausted with %0d reads still waiting for valid",
                                     exp0_q.size() + exp1_q.size()));
        end
        // idle tail, counters must fall back to 0
        wait_cnt = 0;
        while (wait_cnt < 3) begin
            @(posedge clk);
            wait_cnt++;
        end
    endtask

    initial begin
        int fd;
        drive_idle();
        rst           = 1'b1;
        run_len[0]    = 0;
        run_len[1]    = 0;
        prev_valid[0] = 1'b0;
        prev_valid[1] = 1'b0;
        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            report_failure($sformatf("cannot open trace file %s", TRACE_FILE));
        end else begin
            replay_trace(fd);
            $fclose(fd);
            drain_reads();
        end

        $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+.
awe_rowbuf_pkg.sv
rowbuf_cmd_if.sv
awe_seq_decoder.sv
awe_row_bank.sv
awe_ce_output.sv
awe_rowbuffers.sv
tb_awe_rowbuffers.sv
